//--- Bender.yml
package:
  name: rob_core

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - rob_pkg.sv
  - dispatch_stage.sv
  - reorder_buffer.sv
  - retire_stage.sv
  - rob_core.sv
  - target: test
    files:
      - rob_core_tb.sv

//--- dispatch_stage.sv
/*
 * input side of rob_core: one-entry holding register between the
 * instruction source and the ROB, classifies the opcode on entry
 */
`include "rob_core_defines.svh"

module dispatch_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    // instruction source
    input  logic                  insn_valid,
    output logic                  insn_ready,
    input  isa_pkg::opcode_t      insn_opcode,
    input  isa_pkg::reg_idx_t     insn_dest,
    // slot request towards the ROB
    output logic                  alloc_req,
    output isa_pkg::commit_kind_t alloc_kind,
    output isa_pkg::reg_idx_t     alloc_dest,
    input  logic                  alloc_grant
);
    import isa_pkg::*;

    //////////////////////////////
    // opcode classification
    //////////////////////////////

    function automatic commit_kind_t classify(input opcode_t opcode);
        case (opcode)
            `RV32_LOAD,
            `RV32_OP_IMM,
            `RV32_OP,
            `RV32_JAL,
            `RV32_JALR,
            `RV32_LUI,
            `RV32_AUIPC:  return KIND_REG;
            `RV32_STORE:  return KIND_STORE;
            // branches and unknown opcodes resolve outside this slice
            default:      return KIND_NONE;
        endcase
    endfunction

    //////////////////////////////
    // holding register
    //////////////////////////////

    // room when empty or when the held one leaves on this edge
    // nothing is taken in while a flush is wiping the pipe
    assign insn_ready = (!alloc_req || alloc_grant) && !flush;

    // occupancy flag
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alloc_req <= 1'b0;
        end else if (flush) begin
            alloc_req <= 1'b0;
        end else if (insn_valid && insn_ready) begin
            alloc_req <= 1'b1;
        end else if (alloc_grant) begin
            alloc_req <= 1'b0;
        end
    end

    // kind and destination, loaded with each accepted instruction
    always_ff @(posedge clock) begin
        if (insn_valid && insn_ready) begin
            alloc_kind <= classify(insn_opcode);
            alloc_dest <= insn_dest;
        end
    end

    // a waiting request keeps its payload until the ROB grants it
    held_stable_a: assert property (@(posedge clock) disable iff (reset)
        alloc_req && !alloc_grant && !flush
        |=> alloc_req && $stable(alloc_kind) && $stable(alloc_dest))
        else $error("dispatch payload changed while waiting for grant");

endmodule

//--- isa_pkg.sv
/*
 * instruction level types: opcode, register index, data word and
 * the kind of effect an instruction has when it commits
 */
package isa_pkg;

    // major opcode field of an RV32 instruction
    typedef logic [6:0] opcode_t;

    // architectural register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // register or result value
    typedef logic [31:0] word_t;

    // what a commit does to architectural state
    //   KIND_NONE   branch or unrecognised opcode
    //   KIND_REG    writes the destination register
    //   KIND_STORE  value carries a store address
    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_REG   = 2'd1,
        KIND_STORE = 2'd2
    } commit_kind_t;

endpackage

//--- reorder_buffer.sv
/*
 * circular re-order buffer: allocates at the tail, takes completions
 * by tag, serves operand reads and frees finished entries at the head
 */
`include "rob_core_defines.svh"

module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    // allocation from dispatch
    input  logic                  alloc_req,
    input  isa_pkg::commit_kind_t alloc_kind,
    input  isa_pkg::reg_idx_t     alloc_dest,
    output logic                  alloc_grant,
    output rob_pkg::rob_tag_t     alloc_tag,
    // completion, always accepted
    input  logic                  complete_valid,
    input  rob_pkg::rob_tag_t     complete_tag,
    input  isa_pkg::word_t        complete_value,
    // operand read by tag
    input  rob_pkg::rob_tag_t     read_tag,
    output logic                  read_ready,
    output isa_pkg::word_t        read_value,
    // oldest entry towards retire
    output logic                  head_valid,
    output isa_pkg::commit_kind_t head_kind,
    output isa_pkg::reg_idx_t     head_dest,
    output isa_pkg::word_t        head_value,
    input  logic                  head_take
);
    import isa_pkg::*;
    import rob_pkg::*;

    // per-slot storage
    entry_state_t state_q [`ROB_DEPTH];
    commit_kind_t kind_q  [`ROB_DEPTH];
    reg_idx_t     dest_q  [`ROB_DEPTH];
    word_t        value_q [`ROB_DEPTH];

    // pointers carry a wrap bit above the index
    rob_ptr_t head_ptr;
    rob_ptr_t tail_ptr;
    rob_tag_t head_idx;
    rob_tag_t tail_idx;
    logic     full;
    logic     empty;

    assign head_idx = head_ptr[`ROB_TAG_W-1:0];
    assign tail_idx = tail_ptr[`ROB_TAG_W-1:0];

    // same slot, wrap bits tell full from empty
    assign empty = (head_ptr == tail_ptr);
    assign full  = (head_idx == tail_idx) && (head_ptr[`ROB_TAG_W] != tail_ptr[`ROB_TAG_W]);

    //////////////////////////////
    // allocation
    //////////////////////////////

    // the tail slot is offered every cycle
    assign alloc_tag   = tail_idx;
    assign alloc_grant = alloc_req && !full && !flush;

    //////////////////////////////
    // operand read
    //////////////////////////////

    assign read_ready = (state_q[read_tag] == ENTRY_READY);
    // zero until the result is in
    assign read_value = read_ready ? value_q[read_tag] : '0;

    //////////////////////////////
    // head towards retire
    //////////////////////////////

    assign head_valid = !empty && (state_q[head_idx] == ENTRY_READY) && !flush;
    assign head_kind  = kind_q[head_idx];
    assign head_dest  = dest_q[head_idx];
    assign head_value = value_q[head_idx];

    //////////////////////////////
    // state and pointers
    //////////////////////////////

    // allocate, complete and free touch different slots, so all
    // three can land on the same edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ENTRY_EMPTY;
            end
        end else if (flush) begin
            // drop everything in flight
            head_ptr <= tail_ptr;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ENTRY_EMPTY;
            end
        end else begin
            if (complete_valid) begin
                state_q[complete_tag] <= ENTRY_READY;
            end
            if (head_take) begin
                state_q[head_idx] <= ENTRY_EMPTY;
                head_ptr          <= head_ptr + 1'b1;
            end
            if (alloc_grant) begin
                state_q[tail_idx] <= ENTRY_BUSY;
                tail_ptr          <= tail_ptr + 1'b1;
            end
        end
    end

    // payload of each slot
    always_ff @(posedge clock) begin
        if (alloc_grant) begin
            kind_q[tail_idx] <= alloc_kind;
            dest_q[tail_idx] <= alloc_dest;
        end
        if (complete_valid) begin
            value_q[complete_tag] <= complete_value;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // execution side may only finish an instruction still in flight
    complete_busy_a: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> state_q[complete_tag] == ENTRY_BUSY)
        else $error("completion to tag %0d which is not busy", complete_tag);

    // retire must not pull an entry the buffer does not offer
    take_valid_a: assert property (@(posedge clock) disable iff (reset)
        head_take |-> head_valid)
        else $error("head taken while not valid");

endmodule

//--- retire_stage.sv
/*
 * output side of rob_core: commit register with back-pressure and the
 * architectural register file written by register commits
 */
module retire_stage (
    input  logic                  clock,
    input  logic                  reset,
    // oldest finished entry from the ROB
    input  logic                  head_valid,
    input  isa_pkg::commit_kind_t head_kind,
    input  isa_pkg::reg_idx_t     head_dest,
    input  isa_pkg::word_t        head_value,
    output logic                  head_take,
    // commit port
    output logic                  commit_valid,
    input  logic                  commit_ready,
    output isa_pkg::commit_kind_t commit_kind,
    output isa_pkg::reg_idx_t     commit_dest,
    output isa_pkg::word_t        commit_value,
    // architectural read
    input  isa_pkg::reg_idx_t     arch_idx,
    output isa_pkg::word_t        arch_value
);
    import isa_pkg::*;

    // x0 is kept but never written
    word_t arch_q [32];

    // take when the commit register is free or draining now
    assign head_take = head_valid && (!commit_valid || commit_ready);

    //////////////////////////////
    // commit register
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (head_take) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (head_take) begin
            commit_kind  <= head_kind;
            // dest only means something for register writers
            commit_dest  <= (head_kind == KIND_REG) ? head_dest : '0;
            commit_value <= head_value;
        end
    end

    //////////////////////////////
    // register file
    //////////////////////////////

    // written on the edge the commit loads, not when it is accepted
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                arch_q[i] <= '0;
            end
        end else if (head_take && head_kind == KIND_REG && head_dest != '0) begin
            arch_q[head_dest] <= head_value;
        end
    end

    // x0 keeps its reset zero
    assign arch_value = arch_q[arch_idx];

    // a stalled commit must not move under the consumer
    commit_hold_a: assert property (@(posedge clock) disable iff (reset)
        commit_valid && !commit_ready
        |=> commit_valid && $stable(commit_kind) && $stable(commit_dest)
            && $stable(commit_value))
        else $error("commit changed while stalled");

endmodule

//--- rob_core.f
+incdir+.
isa_pkg.sv
rob_pkg.sv
dispatch_stage.sv
reorder_buffer.sv
retire_stage.sv
rob_core.sv
rob_core_tb.sv

//--- rob_core.sv
/*
 * top of the ROB core slice: dispatch, re-order buffer and retire
 * wired to the external instruction, completion and commit ports
 */
module rob_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    // instruction port
    input  logic                  insn_valid,
    output logic                  insn_ready,
    input  isa_pkg::opcode_t      insn_opcode,
    input  isa_pkg::reg_idx_t     insn_dest,
    // tag given to each dispatched instruction
    output logic                  issue_valid,
    output rob_pkg::rob_tag_t     issue_tag,
    // completion port
    input  logic                  complete_valid,
    input  rob_pkg::rob_tag_t     complete_tag,
    input  isa_pkg::word_t        complete_value,
    // operand read port
    input  rob_pkg::rob_tag_t     read_tag,
    output logic                  read_ready,
    output isa_pkg::word_t        read_value,
    // commit port
    output logic                  commit_valid,
    input  logic                  commit_ready,
    output isa_pkg::commit_kind_t commit_kind,
    output isa_pkg::reg_idx_t     commit_dest,
    output isa_pkg::word_t        commit_value,
    // architectural read port
    input  isa_pkg::reg_idx_t     arch_idx,
    output isa_pkg::word_t        arch_value
);
    import isa_pkg::*;

    // dispatch to ROB
    logic         alloc_req;
    commit_kind_t alloc_kind;
    reg_idx_t     alloc_dest;
    logic         alloc_grant;

    // ROB to retire
    logic         head_valid;
    commit_kind_t head_kind;
    reg_idx_t     head_dest;
    word_t        head_value;
    logic         head_take;

    // a grant is the moment a tag is handed out
    assign issue_valid = alloc_grant;

    dispatch_stage dispatch_i (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .insn_valid  (insn_valid),
        .insn_ready  (insn_ready),
        .insn_opcode (insn_opcode),
        .insn_dest   (insn_dest),
        .alloc_req   (alloc_req),
        .alloc_kind  (alloc_kind),
        .alloc_dest  (alloc_dest),
        .alloc_grant (alloc_grant)
    );

    reorder_buffer rob_i (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .alloc_req      (alloc_req),
        .alloc_kind     (alloc_kind),
        .alloc_dest     (alloc_dest),
        .alloc_grant    (alloc_grant),
        .alloc_tag      (issue_tag),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .complete_value (complete_value),
        .read_tag       (read_tag),
        .read_ready     (read_ready),
        .read_value     (read_value),
        .head_valid     (head_valid),
        .head_kind      (head_kind),
        .head_dest      (head_dest),
        .head_value     (head_value),
        .head_take      (head_take)
    );

    retire_stage retire_i (
        .clock        (clock),
        .reset        (reset),
        .head_valid   (head_valid),
        .head_kind    (head_kind),
        .head_dest    (head_dest),
        .head_value   (head_value),
        .head_take    (head_take),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_kind  (commit_kind),
        .commit_dest  (commit_dest),
        .commit_value (commit_value),
        .arch_idx     (arch_idx),
        .arch_value   (arch_value)
    );

endmodule

//--- rob_core_defines.svh
/*
 * sizing and RV32 opcode constants shared by the rob_core sources;
 * include this before any package or module that needs them
 */
`ifndef ROB_CORE_DEFINES_SVH
`define ROB_CORE_DEFINES_SVH

//////////////////////////////
// buffer sizing
//////////////////////////////

// number of in-flight slots, any power of two works
`define ROB_DEPTH 16
// log2 of the depth, keep in step with the line above
`define ROB_TAG_W 4

//////////////////////////////
// RV32 major opcodes
//////////////////////////////

`define RV32_LOAD   7'b0000011
`define RV32_STORE  7'b0100011
`define RV32_OP_IMM 7'b0010011
`define RV32_OP     7'b0110011
`define RV32_JAL    7'b1101111
`define RV32_JALR   7'b1100111
`define RV32_LUI    7'b0110111
`define RV32_AUIPC  7'b0010111
// conditional branches, they never commit a register
`define RV32_BRANCH 7'b1100011

`endif

//--- rob_core_tb.sv
/*
 * self-checking testbench for rob_core: random instructions, random-order
 * completion, back-pressure and flush, checked against an in-order model
 */
`include "rob_core_defines.svh"

module rob_core_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int SEQ_LEN     = 64;
    localparam int FLUSH_LEN   = 6;
    // upper bound on instructions the whole run can send
    localparam int TOTAL_INSNS = SEQ_LEN + 4 * `ROB_DEPTH + FLUSH_LEN + 1;

    logic         clock;
    logic         reset;
    logic         flush;
    logic         insn_valid;
    logic         insn_ready;
    opcode_t      insn_opcode;
    reg_idx_t     insn_dest;
    logic         issue_valid;
    rob_tag_t     issue_tag;
    logic         complete_valid;
    rob_tag_t     complete_tag;
    word_t        complete_value;
    rob_tag_t     read_tag;
    logic         read_ready;
    word_t        read_value;
    logic         commit_valid;
    logic         commit_ready;
    commit_kind_t commit_kind;
    reg_idx_t     commit_dest;
    word_t        commit_value;
    reg_idx_t     arch_idx;
    word_t        arch_value;

    integer seed = 32'h8b73_2e02;
    int     errors;
    int     checks;
    logic   hold_commit;

    // model state, one queue slot per instruction in program order
    opcode_t      sent_opcode [$];
    reg_idx_t     sent_dest   [$];
    rob_tag_t     exp_tag     [$];
    commit_kind_t exp_kind    [$];
    reg_idx_t     exp_dest    [$];
    word_t        exp_value   [$];
    rob_tag_t     pending_tags [$];
    word_t        model_regs  [32];
    int           committed_total;
    // tag the next issue should carry, unknown after reset and flush
    rob_tag_t     next_tag;
    logic         tag_known;

    // last entry is SYSTEM, which nothing here classifies
    opcode_t opcode_table [10] = '{`RV32_LOAD, `RV32_STORE, `RV32_OP_IMM, `RV32_OP,
        `RV32_JAL, `RV32_JALR, `RV32_LUI, `RV32_AUIPC, `RV32_BRANCH, 7'b1110011};

    rob_core dut_i (.*);

    always #50 clock = ~clock;

    //////////////////////////////
    // reference and checks
    //////////////////////////////

    function automatic commit_kind_t expected_kind(input opcode_t opcode);
        if (opcode == `RV32_STORE) begin
            return KIND_STORE;
        end
        if (opcode inside {`RV32_LOAD, `RV32_OP_IMM, `RV32_OP, `RV32_JAL,
                           `RV32_JALR, `RV32_LUI, `RV32_AUIPC}) begin
            return KIND_REG;
        end
        return KIND_NONE;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // drop model entries from the back until only keep remain
    task automatic trim_expected(input int keep);
        while (exp_tag.size() > keep) begin
            exp_tag.delete(exp_tag.size() - 1);
            exp_kind.delete(exp_kind.size() - 1);
            exp_dest.delete(exp_dest.size() - 1);
            exp_value.delete(exp_value.size() - 1);
        end
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic load_random_insn;
        insn_opcode = opcode_table[$unsigned($random(seed)) % 10];
        insn_dest   = reg_idx_t'($random(seed));
        insn_valid  = 1'b1;
    endtask

    // called 10 units after an edge, returns at the same phase
    task automatic send_random_insn;
        load_random_insn();
        do @(posedge clock); while (!insn_ready);
        #10;
        insn_valid = 1'b0;
    endtask

    // wait until dispatch and the model have nothing left
    task automatic drain;
        do begin
            @(posedge clock);
            #10;
        end while (exp_kind.size() != 0 || sent_opcode.size() != 0);
    endtask

    task automatic check_arch(input string name);
        for (int i = 0; i < 32; i++) begin
            arch_idx = reg_idx_t'(i);
            #10;
            check(name, model_regs[i], arch_value);
            @(posedge clock);
            #10;
        end
    endtask

    //////////////////////////////
    // compare process
    //////////////////////////////

    // runs on every edge, sees values settled before it
    always @(posedge clock) begin : compare_commits
        opcode_t      opcode;
        reg_idx_t     dest;
        commit_kind_t kind;
        if (!reset) begin
            if (commit_valid && commit_ready) begin
                committed_total++;
                if (exp_kind.size() == 0) begin
                    errors++;
                    $display("commit accepted while no instruction was outstanding");
                end else begin
                    check("commit_kind", exp_kind[0], commit_kind);
                    check("commit_dest", exp_dest[0], commit_dest);
                    check("commit_value", exp_value[0], commit_value);
                    if (exp_kind[0] == KIND_REG && exp_dest[0] != 0) begin
                        model_regs[exp_dest[0]] = exp_value[0];
                    end
                    exp_tag.delete(0);
                    exp_kind.delete(0);
                    exp_dest.delete(0);
                    exp_value.delete(0);
                end
            end
            // a stalled commit survives the flush, the rest is gone
            if (flush) begin
                trim_expected((commit_valid && !commit_ready) ? 1 : 0);
                sent_opcode.delete();
                sent_dest.delete();
                pending_tags.delete();
                tag_known = 1'b0;
            end
            if (issue_valid) begin
                if (sent_opcode.size() == 0) begin
                    errors++;
                    $display("tag issued with no instruction waiting in dispatch");
                end else begin
                    opcode = sent_opcode.pop_front();
                    dest   = sent_dest.pop_front();
                    kind   = expected_kind(opcode);
                    exp_tag.push_back(issue_tag);
                    exp_kind.push_back(kind);
                    exp_dest.push_back((kind == KIND_REG) ? dest : 5'd0);
                    exp_value.push_back('0);
                    pending_tags.push_back(issue_tag);
                end
                // slots are handed out one after another round the ring
                if (tag_known) begin
                    check("issue_tag", next_tag, issue_tag);
                end else begin
                    next_tag = issue_tag;
                end
                next_tag  = next_tag + 1'b1;
                tag_known = 1'b1;
            end
            if (insn_valid && insn_ready) begin
                sent_opcode.push_back(insn_opcode);
                sent_dest.push_back(insn_dest);
            end
        end
    end

    //////////////////////////////
    // completer and commit consumer
    //////////////////////////////

    initial begin : completer
        int       idx;
        rob_tag_t tag;
        word_t    value;
        logic     landed;
        @(negedge reset);
        forever begin
            @(posedge clock);
            #10;
            commit_ready   = hold_commit ? 1'b0 : ($random(seed) % 4 != 0);
            complete_valid = 1'b0;
            if (pending_tags.size() != 0 && ($random(seed) % 4 != 0)) begin
                // any outstanding tag, so results come back out of order
                idx   = $unsigned($random(seed)) % pending_tags.size();
                tag   = pending_tags[idx];
                value = $random(seed);
                pending_tags.delete(idx);
                // newest model entry with this tag is the one in flight
                for (int i = exp_tag.size() - 1; i >= 0; i--) begin
                    if (exp_tag[i] == tag) begin
                        exp_value[i] = value;
                        break;
                    end
                end
                complete_valid = 1'b1;
                complete_tag   = tag;
                complete_value = value;
                read_tag       = tag;
                #10;
                check("read_before_complete", 0, read_ready);
                landed = !flush;
                @(posedge clock);
                #10;
                commit_ready   = hold_commit ? 1'b0 : ($random(seed) % 4 != 0);
                complete_valid = 1'b0;
                #10;
                if (landed) begin
                    check("read_after_complete", 1, read_ready);
                    check("read_value", value, read_value);
                end
            end
        end
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin : watchdog
        #(100 * 200 * TOTAL_INSNS);
        $display("watchdog expired after %0d cycles, run stopped", 200 * TOTAL_INSNS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin : main
        int   accepted;
        int   held;
        int   base;
        logic took;
        clock          = 1'b0;
        reset          = 1'b1;
        flush          = 1'b0;
        insn_valid     = 1'b0;
        insn_opcode    = '0;
        insn_dest      = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        complete_value = '0;
        read_tag       = '0;
        commit_ready   = 1'b0;
        arch_idx       = '0;
        hold_commit    = 1'b0;
        next_tag       = '0;
        tag_known      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        #10;
        reset = 1'b0;

        // reset state
        #10;
        check("reset_commit_valid", 0, commit_valid);
        check("reset_issue_valid", 0, issue_valid);
        check("reset_insn_ready", 1, insn_ready);
        @(posedge clock);
        #10;
        check_arch("reset_arch");

        // in-order commit of randomly completed instructions
        repeat (SEQ_LEN) send_random_insn();
        drain();
        check("seq_commit_count", SEQ_LEN, committed_total);
        check_arch("seq_arch");

        // back-pressure, the pipe fills and dispatch stops
        hold_commit = 1'b1;
        base        = committed_total;
        @(posedge clock);
        #10;
        accepted = 0;
        took     = 1'b0;
        load_random_insn();
        for (int c = 0; c < 4 * `ROB_DEPTH; c++) begin
            @(posedge clock);
            took = insn_ready;
            #10;
            if (took) begin
                accepted++;
                load_random_insn();
            end
        end
        check("bp_ready_low", 0, took);
        check("bp_accept_limit", 1, accepted <= `ROB_DEPTH + 2);
        hold_commit = 1'b0;
        do begin
            @(posedge clock);
            took = insn_ready;
            #10;
        end while (!took);
        insn_valid = 1'b0;
        drain();
        // every instruction sent here, the last one included, commits once
        check("bp_commit_count", accepted + 1, committed_total - base);

        // flush with work in flight and a commit held
        hold_commit = 1'b1;
        @(posedge clock);
        #10;
        repeat (FLUSH_LEN) send_random_insn();
        repeat (12) @(posedge clock);
        #10;
        flush = 1'b1;
        @(posedge clock);
        #10;
        flush       = 1'b0;
        held        = exp_kind.size();
        base        = committed_total;
        hold_commit = 1'b0;
        send_random_insn();
        drain();
        check("flush_commit_count", held + 1, committed_total - base);
        check_arch("final_arch");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- rob_pkg.sv
/*
 * buffer level types of the re-order buffer: slot tags, wrap-bit
 * pointers and the state kept for each entry
 */
`include "rob_core_defines.svh"

package rob_pkg;

    // slot index handed out at dispatch
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // slot index with an extra wrap bit on top
    typedef logic [`ROB_TAG_W:0] rob_ptr_t;

    // lifetime of a slot
    typedef enum logic [1:0] {
        ENTRY_EMPTY = 2'd0,
        ENTRY_BUSY  = 2'd1,
        ENTRY_READY = 2'd2
    } entry_state_t;

endpackage
